//--- hdl/sha512_pkg.sv
// memory request types, block and digest types, FSM states, start code, SHA-512 constants

package sha512_pkg;

  // ------------------------------
  // host memory interface
  // ------------------------------

  typedef logic [41:0]  cl_addr_t;
  typedef logic [511:0] cl_data_t;

  typedef struct packed {
    cl_addr_t    address;
    logic [31:0] size;
  } hc_buffer_t;

  // every read asks for two consecutive lines
  typedef struct packed {
    logic     valid;
    cl_addr_t address;
  } mem_rd_req_t;

  typedef struct packed {
    logic     valid;
    cl_data_t data;
  } mem_rd_rsp_t;

  typedef struct packed {
    logic     valid;
    cl_addr_t address;
    cl_data_t data;
  } mem_wr_req_t;

  localparam logic [31:0] hc_control_start = 32'h0000_0001;

  // ------------------------------
  // hashing
  // ------------------------------

  // first line of the pair sits in the upper half
  typedef struct packed {
    logic [1023:0] data;
    logic          first;
  } block_t;

  typedef logic [511:0] digest_t;

  typedef enum logic [2:0] {
    rd_idle,
    rd_fetch,
    rd_wait_0,
    rd_wait_1,
    rd_finish
  } rd_state_t;

  typedef enum logic [2:0] {
    wr_idle,
    wr_check,
    wr_data,
    wr_finish_1,
    wr_finish_2
  } wr_state_t;

  localparam logic [63:0] sha512_k [0:79] = '{
    64'h428a2f98d728ae22, 64'h7137449123ef65cd, 64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
    64'h3956c25bf348b538, 64'h59f111f1b605d019, 64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
    64'hd807aa98a3030242, 64'h12835b0145706fbe, 64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
    64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1, 64'h9bdc06a725c71235, 64'hc19bf174cf692694,
    64'he49b69c19ef14ad2, 64'hefbe4786384f25e3, 64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
    64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483, 64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
    64'h983e5152ee66dfab, 64'ha831c66d2db43210, 64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
    64'hc6e00bf33da88fc2, 64'hd5a79147930aa725, 64'h06ca6351e003826f, 64'h142929670a0e6e70,
    64'h27b70a8546d22ffc, 64'h2e1b21385c26c926, 64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
    64'h650a73548baf63de, 64'h766a0abb3c77b2a8, 64'h81c2c92e47edaee6, 64'h92722c851482353b,
    64'ha2bfe8a14cf10364, 64'ha81a664bbc423001, 64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
    64'hd192e819d6ef5218, 64'hd69906245565a910, 64'hf40e35855771202a, 64'h106aa07032bbd1b8,
    64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53, 64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
    64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb, 64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
    64'h748f82ee5defb2fc, 64'h78a5636f43172f60, 64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
    64'h90befffa23631e28, 64'ha4506cebde82bde9, 64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
    64'hca273eceea26619c, 64'hd186b8c721c0c207, 64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
    64'h06f067aa72176fba, 64'h0a637dc5a2c898a6, 64'h113f9804bef90dae, 64'h1b710b35131c471b,
    64'h28db77f523047d84, 64'h32caab7b40c72493, 64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
    64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a, 64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
  };

  localparam logic [63:0] sha512_h0 [0:7] = '{
    64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b, 64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1, 64'h9b05688c2b3e6c1f, 64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
  };

endpackage : sha512_pkg

//--- hdl/sha512_fifo.sv
// circular block queue with count based full and empty flags

module sha512_fifo import sha512_pkg::*; #(
  parameter int fifo_depth = 4
) (
  input  logic   clk,
  input  logic   reset,
  input  block_t enq_data,
  input  logic   enq_en,
  input  logic   deq_en,
  output block_t deq_data,
  output logic   not_full,
  output logic   not_empty
);

  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w = $clog2(fifo_depth + 1);

  block_t mem [fifo_depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_enq;
  logic             do_deq;

  assign not_full  = (count != cnt_w'(fifo_depth));
  assign not_empty = (count != '0);
  assign do_enq    = enq_en && not_full;
  assign do_deq    = deq_en && not_empty;
  assign deq_data  = mem[rd_ptr];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_deq) begin
        rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leave the count alone
      if (do_enq && !do_deq) begin
        count <= count + 1'b1;
      end else if (do_deq && !do_enq) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_enq) begin
      mem[wr_ptr] <= enq_data;
    end
  end

endmodule : sha512_fifo

//--- hdl/sha512_requestor.sv
// read fetch engine, block queue and feed, digest counter and write engine

module sha512_requestor import sha512_pkg::*; #(
  parameter int fifo_depth = 4
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] hc_control,
  input  cl_addr_t    dsm_base,
  input  hc_buffer_t  src_buffer,
  input  hc_buffer_t  dst_buffer,
  input  logic        rd_alm_full,
  input  logic        wr_alm_full,
  input  mem_rd_rsp_t rd_rsp,
  input  digest_t     digest,
  input  logic        digest_valid,
  input  logic        ready,
  output mem_rd_req_t rd_req,
  output mem_wr_req_t wr_req,
  output block_t      blk,
  output logic        blk_valid
);

  logic   start;
  block_t enq_data;
  block_t deq_data;
  logic   enq_en;
  logic   deq_en;
  logic   not_full;
  logic   not_empty;

  assign start = (hc_control == hc_control_start);

  sha512_fifo #(
    .fifo_depth (fifo_depth)
  ) sha512_fifo_i (
    .clk       (clk),
    .reset     (reset),
    .enq_data  (enq_data),
    .enq_en    (enq_en),
    .deq_en    (deq_en),
    .deq_data  (deq_data),
    .not_full  (not_full),
    .not_empty (not_empty)
  );

  // ------------------------------
  // read engine
  // ------------------------------

  rd_state_t   rd_state;
  rd_state_t   rd_next_state;
  logic [31:0] rd_offset;
  logic        fetch_go;
  logic        rsp_second;
  logic        first_pair;
  cl_data_t    first_line;

  // queue space checked too, the core may lag behind memory
  assign fetch_go = (rd_state == rd_fetch) && !rd_alm_full && not_full;

  always_comb begin
    rd_next_state = rd_state;
    case (rd_state)
      rd_idle:   if (start) rd_next_state = rd_fetch;
      rd_fetch: begin
        if (fetch_go) begin
          rd_next_state = ((rd_offset + 32'd2) == src_buffer.size) ? rd_finish : rd_wait_0;
        end
      end
      rd_wait_0: if (rd_rsp.valid) rd_next_state = rd_wait_1;
      rd_wait_1: if (rd_rsp.valid) rd_next_state = rd_fetch;
      default:   rd_next_state = rd_state;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_state  <= rd_idle;
      rd_offset <= '0;
      rd_req    <= '0;
    end else begin
      rd_state     <= rd_next_state;
      rd_req.valid <= fetch_go;
      if (fetch_go) begin
        rd_req.address <= src_buffer.address + cl_addr_t'(rd_offset);
        rd_offset      <= rd_offset + 32'd2;
      end
    end
  end

  // pair the two responses of each request
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rsp_second <= 1'b0;
      first_pair <= 1'b1;
    end else if (rd_rsp.valid) begin
      rsp_second <= !rsp_second;
      if (rsp_second) begin
        first_pair <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_rsp.valid && !rsp_second) begin
      first_line <= rd_rsp.data;
    end
  end

  assign enq_en = rd_rsp.valid && rsp_second;

  always_comb begin
    enq_data.data  = {first_line, rd_rsp.data};
    enq_data.first = first_pair;
  end

  // ------------------------------
  // block feed
  // ------------------------------

  assign deq_en = ready && not_empty;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      blk_valid <= 1'b0;
    end else begin
      blk_valid <= deq_en;
    end
  end

  always_ff @(posedge clk) begin
    if (deq_en) begin
      blk <= deq_data;
    end
  end

  // ------------------------------
  // digest count and write engine
  // ------------------------------

  wr_state_t   wr_state;
  wr_state_t   wr_next_state;
  logic [31:0] digest_cnt;
  logic        prev_digest_valid;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      digest_cnt        <= '0;
      prev_digest_valid <= 1'b0;
    end else begin
      prev_digest_valid <= digest_valid;
      if (digest_valid && !prev_digest_valid) begin
        digest_cnt <= digest_cnt + 32'd1;
      end
    end
  end

  always_comb begin
    wr_next_state = wr_state;
    case (wr_state)
      wr_idle:     if (start) wr_next_state = wr_check;
      wr_check:    if (digest_cnt == {1'b0, src_buffer.size[31:1]}) wr_next_state = wr_data;
      wr_data:     if (!wr_alm_full) wr_next_state = wr_finish_1;
      wr_finish_1: if (!wr_alm_full) wr_next_state = wr_finish_2;
      default:     wr_next_state = wr_state;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_state <= wr_idle;
      wr_req   <= '0;
    end else begin
      wr_state     <= wr_next_state;
      wr_req.valid <= 1'b0;
      if (wr_state == wr_data && !wr_alm_full) begin
        wr_req.valid   <= 1'b1;
        wr_req.address <= dst_buffer.address;
        wr_req.data    <= cl_data_t'(digest);
      end else if (wr_state == wr_finish_1 && !wr_alm_full) begin
        // completion flag for the host
        wr_req.valid   <= 1'b1;
        wr_req.address <= dsm_base + cl_addr_t'(1);
        wr_req.data    <= cl_data_t'(1);
      end
    end
  end

endmodule : sha512_requestor

//--- hdl/sha512_core.sv
// iterative SHA-512 compression core, one round per cycle, chained across blocks

module sha512_core import sha512_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  block_t  blk,
  input  logic    blk_valid,
  output digest_t digest,
  output logic    digest_valid,
  output logic    ready
);

  logic [63:0] hash [8];
  logic [63:0] wv [8];
  logic [63:0] wv_next [8];
  logic [63:0] w [16];
  logic [63:0] w_next;
  logic [63:0] t1;
  logic [63:0] t2;
  logic [6:0]  round;
  logic        busy;
  logic        load;

  // ------------------------------
  // round functions
  // ------------------------------

  function automatic logic [63:0] rotr(input logic [63:0] x, input int n);
    rotr = (x >> n) | (x << (64 - n));
  endfunction

  function automatic logic [63:0] big_sigma0(input logic [63:0] x);
    big_sigma0 = rotr(x, 28) ^ rotr(x, 34) ^ rotr(x, 39);
  endfunction

  function automatic logic [63:0] big_sigma1(input logic [63:0] x);
    big_sigma1 = rotr(x, 14) ^ rotr(x, 18) ^ rotr(x, 41);
  endfunction

  function automatic logic [63:0] small_sigma0(input logic [63:0] x);
    small_sigma0 = rotr(x, 1) ^ rotr(x, 8) ^ (x >> 7);
  endfunction

  function automatic logic [63:0] small_sigma1(input logic [63:0] x);
    small_sigma1 = rotr(x, 19) ^ rotr(x, 61) ^ (x >> 6);
  endfunction

  function automatic logic [63:0] ch(input logic [63:0] e, input logic [63:0] f,
                                     input logic [63:0] g);
    ch = (e & f) ^ (~e & g);
  endfunction

  function automatic logic [63:0] maj(input logic [63:0] a, input logic [63:0] b,
                                      input logic [63:0] c);
    maj = (a & b) ^ (a & c) ^ (b & c);
  endfunction

  // ------------------------------
  // datapath
  // ------------------------------

  assign load  = blk_valid && !busy;
  assign ready = !busy && !blk_valid;

  always_comb begin
    t1 = wv[7] + big_sigma1(wv[4]) + ch(wv[4], wv[5], wv[6]) + sha512_k[round] + w[0];
    t2 = big_sigma0(wv[0]) + maj(wv[0], wv[1], wv[2]);
    wv_next[0] = t1 + t2;
    wv_next[1] = wv[0];
    wv_next[2] = wv[1];
    wv_next[3] = wv[2];
    wv_next[4] = wv[3] + t1;
    wv_next[5] = wv[4];
    wv_next[6] = wv[5];
    wv_next[7] = wv[6];
    // schedule word needed sixteen rounds from now
    w_next = small_sigma1(w[14]) + w[9] + small_sigma0(w[1]) + w[0];
  end

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      digest[511 - 64*i -: 64] = hash[i];
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      for (int i = 0; i < 16; i++) begin
        w[i] <= blk.data[1023 - 64*i -: 64];
      end
      if (blk.first) begin
        hash <= sha512_h0;
        wv   <= sha512_h0;
      end else begin
        wv <= hash;
      end
    end else if (busy) begin
      wv <= wv_next;
      for (int i = 0; i < 15; i++) begin
        w[i] <= w[i + 1];
      end
      w[15] <= w_next;
      // feed-forward on the last round
      if (round == 7'd79) begin
        for (int i = 0; i < 8; i++) begin
          hash[i] <= hash[i] + wv_next[i];
        end
      end
    end
  end

  // ------------------------------
  // control
  // ------------------------------

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy         <= 1'b0;
      round        <= '0;
      digest_valid <= 1'b0;
    end else begin
      digest_valid <= 1'b0;
      if (load) begin
        busy  <= 1'b1;
        round <= '0;
      end else if (busy) begin
        if (round == 7'd79) begin
          busy         <= 1'b0;
          digest_valid <= 1'b1;
        end else begin
          round <= round + 7'd1;
        end
      end
    end
  end

endmodule : sha512_core

//--- hdl/sha512_top.sv
// top level, requestor with block queue feeding the SHA-512 core

module sha512_top import sha512_pkg::*; #(
  parameter int fifo_depth = 4
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] hc_control,
  input  cl_addr_t    dsm_base,
  input  hc_buffer_t  src_buffer,
  input  hc_buffer_t  dst_buffer,
  input  logic        rd_alm_full,
  input  logic        wr_alm_full,
  input  mem_rd_rsp_t rd_rsp,
  output mem_rd_req_t rd_req,
  output mem_wr_req_t wr_req
);

  block_t  blk;
  logic    blk_valid;
  digest_t digest;
  logic    digest_valid;
  logic    ready;

  sha512_requestor #(
    .fifo_depth (fifo_depth)
  ) sha512_requestor_i (
    .clk          (clk),
    .reset        (reset),
    .hc_control   (hc_control),
    .dsm_base     (dsm_base),
    .src_buffer   (src_buffer),
    .dst_buffer   (dst_buffer),
    .rd_alm_full  (rd_alm_full),
    .wr_alm_full  (wr_alm_full),
    .rd_rsp       (rd_rsp),
    .digest       (digest),
    .digest_valid (digest_valid),
    .ready        (ready),
    .rd_req       (rd_req),
    .wr_req       (wr_req),
    .blk          (blk),
    .blk_valid    (blk_valid)
  );

  sha512_core sha512_core_i (
    .clk          (clk),
    .reset        (reset),
    .blk          (blk),
    .blk_valid    (blk_valid),
    .digest       (digest),
    .digest_valid (digest_valid),
    .ready        (ready)
  );

endmodule : sha512_top

//--- sim/host_memory_model.sv
// host memory model, paired read responses with random delay, read and write logs

module host_memory_model import sha512_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  cl_data_t    lines [16],
  input  logic [3:0]  rsp_delay,
  input  mem_rd_req_t rd_req,
  input  mem_wr_req_t wr_req,
  output mem_rd_rsp_t rd_rsp,
  output int          rd_count,
  output cl_addr_t    rd_addr [8],
  output int          wr_count,
  output cl_addr_t    wr_addr [8],
  output cl_data_t    wr_data [8]
);

  cl_addr_t   rsp_addr;
  logic [3:0] wait_cnt;
  logic [1:0] beats_left;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_rsp     <= '0;
      rsp_addr   <= '0;
      wait_cnt   <= '0;
      beats_left <= '0;
      rd_count   <= 0;
      wr_count   <= 0;
    end else begin
      rd_rsp.valid <= 1'b0;
      if (rd_req.valid) begin
        rsp_addr   <= rd_req.address;
        wait_cnt   <= rsp_delay - 4'd1;
        beats_left <= 2'd2;
        if (rd_count < 8) begin
          rd_addr[rd_count[2:0]] <= rd_req.address;
        end
        rd_count <= rd_count + 1;
      end else if (beats_left != 2'd0) begin
        if (wait_cnt != 4'd0) begin
          wait_cnt <= wait_cnt - 4'd1;
        end else begin
          // two lines back to back, in address order
          rd_rsp.valid <= 1'b1;
          rd_rsp.data  <= lines[rsp_addr[3:0]];
          rsp_addr     <= rsp_addr + 42'd1;
          beats_left   <= beats_left - 2'd1;
        end
      end
      if (wr_req.valid) begin
        if (wr_count < 8) begin
          wr_addr[wr_count[2:0]] <= wr_req.address;
          wr_data[wr_count[2:0]] <= wr_req.data;
        end
        wr_count <= wr_count + 1;
      end
    end
  end

endmodule : host_memory_model

//--- sim/tb_sha512_top.sv
// testbench for sha512_top with clock, reset, watchdog, LFSR, directed tests and checks

module tb_sha512_top import sha512_pkg::*; ();

  localparam cl_addr_t src_base        = 42'h100;
  localparam cl_addr_t dst_base        = 42'h200;
  localparam cl_addr_t dsm_addr        = 42'h300;
  localparam int       total_blocks    = 6;
  localparam int       watchdog_cycles = total_blocks * 200 + 1000;

  localparam logic [23:0]  abc_msg  = "abc";
  localparam logic [895:0] long_msg = {
    "abcdefgh", "bcdefghi", "cdefghij", "defghijk", "efghijkl", "fghijklm", "ghijklmn",
    "hijklmno", "ijklmnop", "jklmnopq", "klmnopqr", "lmnopqrs", "mnopqrst", "nopqrstu"
  };

  // message, one bit, zeros, 128-bit length, left aligned in four lines
  localparam logic [2047:0] abc_padded  = {abc_msg, 8'h80, 864'h0, 128'd24, 1024'h0};
  localparam logic [2047:0] long_padded = {long_msg, 8'h80, 120'h0, 896'h0, 128'd896};

  localparam digest_t abc_digest = {
    64'hddaf35a193617aba, 64'hcc417349ae204131, 64'h12e6fa4e89a97ea2, 64'h0a9eeee64b55d39a,
    64'h2192992a274fc1a8, 64'h36ba3c23a3feebbd, 64'h454d4423643ce80e, 64'h2a9ac94fa54ca49f
  };
  localparam digest_t long_digest = {
    64'h8e959b75dae313da, 64'h8cf4f72814fc143f, 64'h8f7779c6eb9f7fa1, 64'h7299aeadb6889018,
    64'h501d289e4900f7e4, 64'h331b99dec4b5433a, 64'hc7d329eeb6dd2654, 64'h5e96e55b874be909
  };

  logic        clk         = 1'b0;
  logic        reset       = 1'b1;
  logic [31:0] hc_control  = '0;
  cl_addr_t    dsm_base    = '0;
  hc_buffer_t  src_buffer  = '0;
  hc_buffer_t  dst_buffer  = '0;
  logic        rd_alm_full = 1'b0;
  logic        wr_alm_full = 1'b0;
  logic [3:0]  rsp_delay   = 4'd4;
  mem_rd_rsp_t rd_rsp;
  mem_rd_req_t rd_req;
  mem_wr_req_t wr_req;

  cl_data_t    src_lines [16];
  int          rd_count;
  cl_addr_t    rd_addr [8];
  int          wr_count;
  cl_addr_t    wr_addr [8];
  cl_data_t    wr_data [8];

  logic [15:0] lfsr            = 16'd10899;
  logic        pressure_on     = 1'b0;
  logic        rd_alm_prev     = 1'b0;
  logic        wr_alm_prev     = 1'b0;
  int          check_errors    = 0;
  int          protocol_errors = 0;

  sha512_top #(
    .fifo_depth (4)
  ) sha512_top_i (
    .clk         (clk),
    .reset       (reset),
    .hc_control  (hc_control),
    .dsm_base    (dsm_base),
    .src_buffer  (src_buffer),
    .dst_buffer  (dst_buffer),
    .rd_alm_full (rd_alm_full),
    .wr_alm_full (wr_alm_full),
    .rd_rsp      (rd_rsp),
    .rd_req      (rd_req),
    .wr_req      (wr_req)
  );

  host_memory_model host_memory_i (
    .clk       (clk),
    .reset     (reset),
    .lines     (src_lines),
    .rsp_delay (rsp_delay),
    .rd_req    (rd_req),
    .wr_req    (wr_req),
    .rd_rsp    (rd_rsp),
    .rd_count  (rd_count),
    .rd_addr   (rd_addr),
    .wr_count  (wr_count),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  // ------------------------------
  // random delay and almost-full
  // ------------------------------

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  always @(posedge clk) begin : draw_random
    logic [2:0] v;
    for (int i = 0; i < 3; i++) begin
      lfsr = lfsr_next(lfsr);
      v[i] = lfsr[0];
    end
    rsp_delay <= 4'd4 + {1'b0, v % 3'd7};
    if (pressure_on) begin
      lfsr = lfsr_next(lfsr);
      rd_alm_full <= lfsr[0];
      lfsr = lfsr_next(lfsr);
      wr_alm_full <= lfsr[0];
    end else begin
      rd_alm_full <= 1'b0;
      wr_alm_full <= 1'b0;
    end
  end

  // a request may only follow a cycle with almost-full low
  always @(negedge clk) begin
    if (!reset && rd_req.valid && rd_alm_prev) begin
      protocol_errors++;
      $display("read request issued after rd_alm_full was high at time %0t", $time);
    end
    if (!reset && wr_req.valid && wr_alm_prev) begin
      protocol_errors++;
      $display("write request issued after wr_alm_full was high at time %0t", $time);
    end
    rd_alm_prev = rd_alm_full;
    wr_alm_prev = wr_alm_full;
  end

  // ------------------------------
  // helper tasks
  // ------------------------------

  task automatic fill_lines(input logic [2047:0] padded, input int n_lines);
    for (int i = 0; i < 16; i++) begin
      src_lines[i] = {16{32'h5a5a_0000 | 32'(i)}};
    end
    for (int i = 0; i < n_lines; i++) begin
      src_lines[i] = padded[2047 - 512*i -: 512];
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset      <= 1'b1;
    hc_control <= '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic start_job(input int n_lines);
    @(posedge clk);
    src_buffer <= '{src_base, 32'(n_lines)};
    dst_buffer <= '{dst_base, 32'd1};
    dsm_base   <= dsm_addr;
    hc_control <= hc_control_start;
  endtask

  task automatic wait_for_writes(input int count, input int limit);
    int cycles;
    cycles = 0;
    while (wr_count < count && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (wr_count < count) begin
      check_errors++;
      $display("job did not finish within %0d cycles, only %0d writes seen", limit, wr_count);
    end
  endtask

  task automatic check_job(input int n_lines, input digest_t expected);
    if (wr_count != 2) begin
      check_errors++;
      $display("Fail write count: got %0h expected %0h", wr_count, 2);
    end
    if (wr_addr[0] !== dst_base) begin
      check_errors++;
      $display("Fail wr_req.address (digest): got %h expected %h", wr_addr[0], dst_base);
    end
    if (wr_data[0] !== expected) begin
      check_errors++;
      $display("Fail wr_req.data (digest): got %h expected %h", wr_data[0], expected);
    end
    if (wr_addr[1] !== dsm_addr + 42'd1) begin
      check_errors++;
      $display("Fail wr_req.address (status): got %h expected %h", wr_addr[1],
               dsm_addr + 42'd1);
    end
    if (wr_data[1] !== cl_data_t'(1)) begin
      check_errors++;
      $display("Fail wr_req.data (status): got %h expected %h", wr_data[1], cl_data_t'(1));
    end
    if (rd_count != n_lines / 2) begin
      check_errors++;
      $display("Fail read request count: got %0h expected %0h", rd_count, n_lines / 2);
    end
    for (int i = 0; i < n_lines / 2 && i < 8; i++) begin
      if (rd_addr[i] !== src_base + cl_addr_t'(2 * i)) begin
        check_errors++;
        $display("Fail rd_req.address: got %h expected %h", rd_addr[i],
                 src_base + cl_addr_t'(2 * i));
      end
    end
  endtask

  task automatic run_job(input int n_lines, input digest_t expected);
    start_job(n_lines);
    wait_for_writes(2, (n_lines / 2) * 200 + 100);
    // room for any stray extra write
    repeat (20) @(negedge clk);
    check_job(n_lines, expected);
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------

  task automatic test_one_block();
    pressure_on = 1'b0;
    fill_lines(abc_padded, 2);
    apply_reset();
    run_job(2, abc_digest);
  endtask

  task automatic test_two_blocks();
    pressure_on = 1'b0;
    fill_lines(long_padded, 4);
    apply_reset();
    run_job(4, long_digest);
  endtask

  task automatic test_back_pressure();
    pressure_on = 1'b1;
    fill_lines(long_padded, 4);
    apply_reset();
    run_job(4, long_digest);
    pressure_on = 1'b0;
  endtask

  task automatic test_idle_then_rerun();
    pressure_on = 1'b0;
    fill_lines(abc_padded, 2);
    apply_reset();
    repeat (50) @(negedge clk);
    if (rd_req.valid !== 1'b0 || wr_req.valid !== 1'b0) begin
      check_errors++;
      $display("Fail request valid after reset: rd %h wr %h expected 0", rd_req.valid,
               wr_req.valid);
    end
    if (rd_count != 0 || wr_count != 0) begin
      check_errors++;
      $display("Fail requests before start: rd %0h wr %0h expected 0", rd_count, wr_count);
    end
    apply_reset();
    run_job(2, abc_digest);
  endtask

  initial begin
    test_one_block();
    test_two_blocks();
    test_back_pressure();
    test_idle_then_rerun();
    @(posedge clk);
    $display("check errors %0d, protocol errors %0d", check_errors, protocol_errors);
    if (check_errors == 0 && protocol_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * 40 + 10);
    $display("watchdog expired after %0d cycles, check errors %0d, protocol errors %0d",
             watchdog_cycles, check_errors, protocol_errors);
    $display("Test failed");
    $finish;
  end

endmodule : tb_sha512_top

//--- build.f
hdl/sha512_pkg.sv
hdl/sha512_fifo.sv
hdl/sha512_requestor.sv
hdl/sha512_core.sv
hdl/sha512_top.sv
sim/host_memory_model.sv
sim/tb_sha512_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the SHA-512 testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_sha512_top -f build.f -o tb_sha512_top
./obj_dir/tb_sha512_top | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failure"
